// File: hdl/mmc3_pkg.sv
// MMC3 mapper shared types and fixed address constants
// Widths follow the iNES mapper 4 bus layout
`default_nettype none

package mmc3_pkg;

	// Bus widths
	typedef logic [15:0] cpu_addr_t;  // CPU address bus
	typedef logic [7:0]  cpu_data_t;  // CPU data byte
	typedef logic [13:0] ppu_addr_t;  // PPU address bus
	typedef logic [21:0] mem_addr_t;  // Mapped memory address in a 4 MB space

	// Mapper register contents
	typedef logic [5:0]  prg_bank_t;  // 8 KB PRG ROM bank number
	typedef logic [7:0]  chr_page_t;  // 1 KB CHR page number
	typedef logic [2:0]  bank_sel_t;  // Bank register index for $8001
	typedef logic [7:0]  irq_count_t; // Scanline latch and counter

	// Fixed PRG banks at the top of the ROM
	localparam prg_bank_t PRG_BANK_LAST        = 6'b111111; // Always at $E000
	localparam prg_bank_t PRG_BANK_SECOND_LAST = 6'b111110; // $C000 or $8000 by mode

	// PRG ROM sits at the bottom of the memory space
	localparam logic [2:0] PRG_ROM_BASE = 3'b000;

	// Top 9 bits of the 8 KB PRG RAM window
	localparam logic [8:0] PRG_RAM_BASE = 9'b111100000;

	// 256 KB CHR ROM/RAM region starting at 2 MB
	localparam logic [3:0] CHR_BASE = 4'b1000;

	// PPU A12 must stay low this many ce cycles before a rise counts.
	// Filters out the A12 toggles between sprite and background fetches.
	localparam logic [3:0] A12_FILTER_LOAD = 4'd15;

endpackage

`default_nettype wire

// File: hdl/mmc3_reg_decode.sv
// MMC3 CPU register decoder
// Turns writes at $8000-$FFFF into bank, mode, mirroring, RAM and IRQ controls
`default_nettype none

module mmc3_reg_decode (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ce,                // CPU M2 strobe
	input  logic                  prg_write,         // CPU write level
	input  mmc3_pkg::cpu_addr_t   prg_ain,
	input  mmc3_pkg::cpu_data_t   prg_din,
	output logic                  prg_mode,          // Swaps $8000 and $C000 windows
	output logic                  chr_invert,        // Swaps CHR halves
	output logic                  mirror_horizontal,
	output logic                  ram_enable,
	output logic                  ram_protect,
	output mmc3_pkg::prg_bank_t   prg_bank_0,        // R6
	output mmc3_pkg::prg_bank_t   prg_bank_1,        // R7
	output mmc3_pkg::chr_page_t   chr_bank_0,        // R0, 2 KB
	output mmc3_pkg::chr_page_t   chr_bank_1,        // R1, 2 KB
	output mmc3_pkg::chr_page_t   chr_bank_2,        // R2, 1 KB
	output mmc3_pkg::chr_page_t   chr_bank_3,        // R3, 1 KB
	output mmc3_pkg::chr_page_t   chr_bank_4,        // R4, 1 KB
	output mmc3_pkg::chr_page_t   chr_bank_5,        // R5, 1 KB
	output mmc3_pkg::irq_count_t  irq_latch,
	output logic                  irq_reload_wr,     // $C001 write strobe
	output logic                  irq_enable_wr,     // $E001 write strobe
	output logic                  irq_disable_wr     // $E000 write strobe
);

	import mmc3_pkg::*;

	bank_sel_t   bank_select;  // Target of the next $8001 write
	logic        reg_wr;       // Qualified write into mapper space
	logic [2:0]  reg_sel;      // {A14, A13, A0}

	assign reg_wr  = ce && prg_write && prg_ain[15];
	assign reg_sel = {prg_ain[14:13], prg_ain[0]};

	// IRQ control pulses, one clock each
	assign irq_reload_wr  = reg_wr && (reg_sel == 3'b101);
	assign irq_disable_wr = reg_wr && (reg_sel == 3'b110);
	assign irq_enable_wr  = reg_wr && (reg_sel == 3'b111);

	always_ff @(posedge clk) begin
		if (rst) begin
			bank_select       <= '0;
			prg_mode          <= 1'b0;
			chr_invert        <= 1'b0;
			mirror_horizontal <= 1'b0;
			ram_enable        <= 1'b0;
			ram_protect       <= 1'b0;
			prg_bank_0        <= '0;
			prg_bank_1        <= '0;
			chr_bank_0        <= '0;
			chr_bank_1        <= '0;
			chr_bank_2        <= '0;
			chr_bank_3        <= '0;
			chr_bank_4        <= '0;
			chr_bank_5        <= '0;
			irq_latch         <= '0;
		end else if (reg_wr) begin
			case (reg_sel)
				3'b000: begin // $8000 bank select
					chr_invert  <= prg_din[7];
					prg_mode    <= prg_din[6];
					bank_select <= prg_din[2:0];
				end
				3'b001: begin // $8001 bank data
					case (bank_select)
						3'd0: chr_bank_0 <= {prg_din[7:1], 1'b0}; // Even page of the 2 KB pair
						3'd1: chr_bank_1 <= {prg_din[7:1], 1'b0};
						3'd2: chr_bank_2 <= prg_din;
						3'd3: chr_bank_3 <= prg_din;
						3'd4: chr_bank_4 <= prg_din;
						3'd5: chr_bank_5 <= prg_din;
						3'd6: prg_bank_0 <= prg_din[5:0]; // 64 banks max
						3'd7: prg_bank_1 <= prg_din[5:0];
					endcase
				end
				3'b010: mirror_horizontal <= prg_din[0]; // $A000
				3'b011: begin // $A001 RAM control
					ram_enable  <= prg_din[7];
					ram_protect <= prg_din[6];
				end
				3'b100: irq_latch <= prg_din; // $C000
				default: ; // IRQ strobes handled above
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/mmc3_prg_map.sv
// MMC3 PRG address mapping
// Maps CPU addresses onto PRG ROM banks or the PRG RAM window
`default_nettype none

module mmc3_prg_map (
	input  logic                 prg_write,
	input  mmc3_pkg::cpu_addr_t  prg_ain,
	input  logic                 prg_mode,
	input  logic                 ram_enable,
	input  logic                 ram_protect,
	input  mmc3_pkg::prg_bank_t  prg_bank_0,
	input  mmc3_pkg::prg_bank_t  prg_bank_1,
	output mmc3_pkg::mem_addr_t  prg_aout,
	output logic                 prg_allow  // Access granted for this cycle
);

	import mmc3_pkg::*;

	prg_bank_t  prg_sel;  // Bank for the current 8 KB window
	logic       in_ram;   // $6000-$7FFF
	logic       ram_ok;   // RAM access permitted

	// Window select from A14:A13
	always_comb begin
		case ({prg_ain[14:13], prg_mode})
			3'b00_0: prg_sel = prg_bank_0;            // $8000 R6
			3'b00_1: prg_sel = PRG_BANK_SECOND_LAST;  // $8000 fixed in mode 1
			3'b01_0,
			3'b01_1: prg_sel = prg_bank_1;            // $A000 R7 either mode
			3'b10_0: prg_sel = PRG_BANK_SECOND_LAST;  // $C000 fixed in mode 0
			3'b10_1: prg_sel = prg_bank_0;            // $C000 R6 in mode 1
			default: prg_sel = PRG_BANK_LAST;         // $E000 always last
		endcase
	end

	assign in_ram = (prg_ain[15:13] == 3'b011);
	// Protect blocks writes only, reads still pass
	assign ram_ok = in_ram && ram_enable && !(ram_protect && prg_write);

	assign prg_aout = ram_ok ? {PRG_RAM_BASE, prg_ain[12:0]}
	                         : {PRG_ROM_BASE, prg_sel, prg_ain[12:0]};

	// ROM is read only
	assign prg_allow = (prg_ain[15] && !prg_write) || ram_ok;

endmodule

`default_nettype wire

// File: hdl/mmc3_chr_map.sv
// MMC3 CHR address mapping and nametable mirroring
// Picks the 1 KB CHR page and routes nametable accesses to CIRAM
`default_nettype none

module mmc3_chr_map (
	input  mmc3_pkg::ppu_addr_t  chr_ain,
	input  logic                 chr_invert,
	input  logic                 mirror_horizontal,
	input  logic                 chr_is_ram,        // Cart has CHR RAM, writes allowed
	input  mmc3_pkg::chr_page_t  chr_bank_0,
	input  mmc3_pkg::chr_page_t  chr_bank_1,
	input  mmc3_pkg::chr_page_t  chr_bank_2,
	input  mmc3_pkg::chr_page_t  chr_bank_3,
	input  mmc3_pkg::chr_page_t  chr_bank_4,
	input  mmc3_pkg::chr_page_t  chr_bank_5,
	output mmc3_pkg::mem_addr_t  chr_aout,
	output logic                 chr_allow,
	output logic                 vram_a10,          // CIRAM A10
	output logic                 vram_ce            // Route to internal 2 KB VRAM
);

	import mmc3_pkg::*;

	logic       half_sel;  // A12 after inversion
	chr_page_t  chr_sel;   // Selected 1 KB page

	assign half_sel = chr_ain[12] ^ chr_invert;

	// Lower half uses the 2 KB pair registers, upper half the 1 KB ones
	always_comb begin
		case ({half_sel, chr_ain[11:10]})
			3'b000,
			3'b001:  chr_sel = {chr_bank_0[7:1], chr_ain[10]};
			3'b010,
			3'b011:  chr_sel = {chr_bank_1[7:1], chr_ain[10]};
			3'b100:  chr_sel = chr_bank_2;
			3'b101:  chr_sel = chr_bank_3;
			3'b110:  chr_sel = chr_bank_4;
			default: chr_sel = chr_bank_5;
		endcase
	end

	assign chr_aout  = {CHR_BASE, chr_sel, chr_ain[9:0]};
	assign chr_allow = chr_is_ram;

	// Horizontal mirroring pairs $2000/$2400, so A11 picks the table
	assign vram_a10 = mirror_horizontal ? chr_ain[11] : chr_ain[10];
	assign vram_ce  = chr_ain[13];

endmodule

`default_nettype wire

// File: hdl/mmc3_scanline_irq.sv
// MMC3 scanline IRQ counter
// Counts filtered PPU A12 rises and raises the IRQ line at zero
`default_nettype none

module mmc3_scanline_irq (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ce,
	input  mmc3_pkg::ppu_addr_t   chr_ain,
	input  mmc3_pkg::irq_count_t  irq_latch,       // Reload value
	input  logic                  irq_reload_wr,
	input  logic                  irq_enable_wr,
	input  logic                  irq_disable_wr,
	output logic                  irq
);

	import mmc3_pkg::*;

	logic [$bits(A12_FILTER_LOAD)-1:0]  filter_cnt;  // Low time since A12 fell
	irq_count_t                         counter;
	irq_count_t                         next_count;
	logic                               reload_pending;
	logic                               irq_enable;
	logic                               a12;
	logic                               clock_event; // Qualified A12 rise

	assign a12 = chr_ain[12];

	// Only a rise after a long enough low period clocks the counter
	assign clock_event = ce && a12 && (filter_cnt == '0);

	assign next_count = ((counter == '0) || reload_pending) ? irq_latch
	                                                        : counter - 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			filter_cnt     <= '0;
			counter        <= '0;
			reload_pending <= 1'b0;
			irq_enable     <= 1'b0;
			irq            <= 1'b0;
		end else begin
			if (ce) begin
				if (a12)
					filter_cnt <= A12_FILTER_LOAD; // Hold off while A12 high
				else if (filter_cnt != '0)
					filter_cnt <= filter_cnt - 1'b1;
			end

			if (clock_event) begin
				counter        <= next_count;
				reload_pending <= 1'b0;
				// Normal revision fires on every zero, latch 0 included
				if ((next_count == '0) && irq_enable)
					irq <= 1'b1;
			end

			// CPU writes win over a same cycle clock event
			if (irq_reload_wr)
				reload_pending <= 1'b1;
			if (irq_enable_wr)
				irq_enable <= 1'b1;
			if (irq_disable_wr) begin
				irq_enable <= 1'b0;
				irq        <= 1'b0; // Also acknowledges a pending IRQ
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/mmc3_top.sv
// MMC3 mapper top level, iNES mapper 4
// Joins the register decoder with the PRG, CHR and IRQ units
`default_nettype none

module mmc3_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ce,          // CPU M2 strobe
	input  mmc3_pkg::cpu_addr_t  prg_ain,
	input  logic                 prg_write,
	input  mmc3_pkg::cpu_data_t  prg_din,
	input  mmc3_pkg::ppu_addr_t  chr_ain,
	input  logic                 chr_is_ram,
	output mmc3_pkg::mem_addr_t  prg_aout,
	output logic                 prg_allow,
	output mmc3_pkg::mem_addr_t  chr_aout,
	output logic                 chr_allow,
	output logic                 vram_a10,
	output logic                 vram_ce,
	output logic                 irq
);

	import mmc3_pkg::*;

	// Register levels
	logic        prg_mode;
	logic        chr_invert;
	logic        mirror_horizontal;
	logic        ram_enable;
	logic        ram_protect;
	prg_bank_t   prg_bank_0;
	prg_bank_t   prg_bank_1;
	chr_page_t   chr_bank_0;
	chr_page_t   chr_bank_1;
	chr_page_t   chr_bank_2;
	chr_page_t   chr_bank_3;
	chr_page_t   chr_bank_4;
	chr_page_t   chr_bank_5;
	irq_count_t  irq_latch;

	// IRQ control strobes
	logic        irq_reload_wr;
	logic        irq_enable_wr;
	logic        irq_disable_wr;

	mmc3_reg_decode u_reg_decode (
		.clk               (clk),
		.rst               (rst),
		.ce                (ce),
		.prg_write         (prg_write),
		.prg_ain           (prg_ain),
		.prg_din           (prg_din),
		.prg_mode          (prg_mode),
		.chr_invert        (chr_invert),
		.mirror_horizontal (mirror_horizontal),
		.ram_enable        (ram_enable),
		.ram_protect       (ram_protect),
		.prg_bank_0        (prg_bank_0),
		.prg_bank_1        (prg_bank_1),
		.chr_bank_0        (chr_bank_0),
		.chr_bank_1        (chr_bank_1),
		.chr_bank_2        (chr_bank_2),
		.chr_bank_3        (chr_bank_3),
		.chr_bank_4        (chr_bank_4),
		.chr_bank_5        (chr_bank_5),
		.irq_latch         (irq_latch),
		.irq_reload_wr     (irq_reload_wr),
		.irq_enable_wr     (irq_enable_wr),
		.irq_disable_wr    (irq_disable_wr)
	);

	mmc3_prg_map u_prg_map (
		.prg_write   (prg_write),
		.prg_ain     (prg_ain),
		.prg_mode    (prg_mode),
		.ram_enable  (ram_enable),
		.ram_protect (ram_protect),
		.prg_bank_0  (prg_bank_0),
		.prg_bank_1  (prg_bank_1),
		.prg_aout    (prg_aout),
		.prg_allow   (prg_allow)
	);

	mmc3_chr_map u_chr_map (
		.chr_ain           (chr_ain),
		.chr_invert        (chr_invert),
		.mirror_horizontal (mirror_horizontal),
		.chr_is_ram        (chr_is_ram),
		.chr_bank_0        (chr_bank_0),
		.chr_bank_1        (chr_bank_1),
		.chr_bank_2        (chr_bank_2),
		.chr_bank_3        (chr_bank_3),
		.chr_bank_4        (chr_bank_4),
		.chr_bank_5        (chr_bank_5),
		.chr_aout          (chr_aout),
		.chr_allow         (chr_allow),
		.vram_a10          (vram_a10),
		.vram_ce           (vram_ce)
	);

	mmc3_scanline_irq u_scanline_irq (
		.clk            (clk),
		.rst            (rst),
		.ce             (ce),
		.chr_ain        (chr_ain),
		.irq_latch      (irq_latch),
		.irq_reload_wr  (irq_reload_wr),
		.irq_enable_wr  (irq_enable_wr),
		.irq_disable_wr (irq_disable_wr),
		.irq            (irq)
	);

endmodule

`default_nettype wire

// File: tb/mmc3_model.svh
// MMC3 reference model for the testbench
// Expected PRG, CHR, mirroring and scanline counter results
`ifndef MMC3_MODEL_SVH
`define MMC3_MODEL_SVH

// True when the CPU reaches PRG RAM in this access
function automatic logic ram_hit_model(cpu_addr_t a, logic wr, logic en, logic prot);
	return (a >= 16'h6000) && (a < 16'h8000) && en && !(wr && prot); // Protect stops writes only
endfunction

function automatic mem_addr_t prg_addr_model(cpu_addr_t a, logic wr, logic mode,
		prg_bank_t r6, prg_bank_t r7, logic en, logic prot);
	prg_bank_t bank;
	if (ram_hit_model(a, wr, en, prot))
		return {PRG_RAM_BASE, a[12:0]};
	case (a[14:13])
		2'd0:    bank = mode ? PRG_BANK_SECOND_LAST : r6;
		2'd1:    bank = r7;                                 // $A000 never swaps
		2'd2:    bank = mode ? r6 : PRG_BANK_SECOND_LAST;
		default: bank = PRG_BANK_LAST;
	endcase
	return {PRG_ROM_BASE, bank, a[12:0]};
endfunction

function automatic logic prg_allow_model(cpu_addr_t a, logic wr, logic en, logic prot);
	return (a >= 16'h8000 && !wr) || ram_hit_model(a, wr, en, prot); // ROM reads or RAM
endfunction

function automatic mem_addr_t chr_addr_model(ppu_addr_t a, logic inv, cpu_data_t r0,
		cpu_data_t r1, cpu_data_t r2, cpu_data_t r3, cpu_data_t r4, cpu_data_t r5);
	chr_page_t page;
	if ((a[12] ^ inv) == 1'b0)
		page = a[11] ? {r1[7:1], a[10]} : {r0[7:1], a[10]}; // 2 KB pairs, A10 picks the half
	else begin
		case (a[11:10])
			2'd0:    page = r2;
			2'd1:    page = r3;
			2'd2:    page = r4;
			default: page = r5;
		endcase
	end
	return {CHR_BASE, page, a[9:0]};
endfunction

function automatic logic vram_a10_model(ppu_addr_t a, logic horiz);
	return horiz ? a[11] : a[10]; // Horizontal pairs tables by A11
endfunction

// Counter value after one counted A12 rise
function automatic irq_count_t irq_count_model(irq_count_t count, irq_count_t latch, logic reload);
	return (count == 0 || reload) ? latch : count - 8'd1;
endfunction

function automatic logic a12_rise_counts(int low_ce);
	return low_ce >= 15; // Needs a long enough low stretch before the rise
endfunction

`endif

// File: tb/mmc3_tb.sv
// MMC3 mapper testbench
// Random register setups checked against the reference model
`default_nettype none

module mmc3_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import mmc3_pkg::*;
	`include "mmc3_model.svh"

	localparam int MAX_CYCLES = 20000; // Whole run takes about 3000 cycles
	localparam int K_PRG_AOUT = 0;
	localparam int K_PRG_ALLOW = 1;
	localparam int K_CHR_AOUT = 2;
	localparam int K_CHR_ALLOW = 3;
	localparam int K_VRAM_A10 = 4;
	localparam int K_VRAM_CE = 5;
	localparam int K_IRQ = 6;

	logic       clk, rst, ce, prg_write, chr_is_ram;
	cpu_addr_t  prg_ain;
	cpu_data_t  prg_din;
	ppu_addr_t  chr_ain;
	mem_addr_t  prg_aout, chr_aout;
	logic       prg_allow, chr_allow, vram_a10, vram_ce, irq;

	// Shadow of the mapper registers, reset values
	logic       mode_s = 1'b0, inv_s = 1'b0, horiz_s = 1'b0, ram_en_s = 1'b0, ram_prot_s = 1'b0;
	prg_bank_t  r6_s = '0, r7_s = '0;
	cpu_data_t  chr_s [6] = '{default: '0};
	irq_count_t latch_m = '0, count_m = '0;                     // IRQ model state
	logic       reload_m = 1'b0, enable_m = 1'b0, irq_m = 1'b0;
	int         last_gap = 0;                                   // ce cycles low before next rise
	int         pass_cnt = 0, fail_cnt = 0, pass_mark = 0, fail_mark = 0, cycle_cnt;
	logic [31:0] lcg_state = 32'd1;                             // Seed
	int         kind_q [$];                                     // Pending checks
	mem_addr_t  val_q [$];

	mmc3_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.ce         (ce),
		.prg_ain    (prg_ain),
		.prg_write  (prg_write),
		.prg_din    (prg_din),
		.chr_ain    (chr_ain),
		.chr_is_ram (chr_is_ram),
		.prg_aout   (prg_aout),
		.prg_allow  (prg_allow),
		.chr_aout   (chr_aout),
		.chr_allow  (chr_allow),
		.vram_a10   (vram_a10),
		.vram_ce    (vram_ce),
		.irq        (irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16]; // Upper bits are the better ones
	endfunction

	function automatic mem_addr_t output_of(int k);
		case (k)
			K_PRG_AOUT:  return prg_aout;
			K_PRG_ALLOW: return prg_allow;
			K_CHR_AOUT:  return chr_aout;
			K_CHR_ALLOW: return chr_allow;
			K_VRAM_A10:  return vram_a10;
			K_VRAM_CE:   return vram_ce;
			default:     return irq;
		endcase
	endfunction

	function automatic string kind_name(int k);
		case (k)
			K_PRG_AOUT:  return "prg_aout";
			K_PRG_ALLOW: return "prg_allow";
			K_CHR_AOUT:  return "chr_aout";
			K_CHR_ALLOW: return "chr_allow";
			K_VRAM_A10:  return "vram_a10";
			K_VRAM_CE:   return "vram_ce";
			default:     return "irq";
		endcase
	endfunction

	task automatic advance(); // One clock, ce every second cycle
		@(posedge clk);
		#1;
		ce = ~ce;
	endtask

	task automatic expect_value(int k, mem_addr_t v);
		kind_q.push_back(k);
		val_q.push_back(v);
	endtask

	task automatic cpu_write(cpu_addr_t a, cpu_data_t d);
		advance();
		if (!ce)
			advance(); // Write must sit on a ce cycle
		prg_ain = a;
		prg_din = d;
		prg_write = 1'b1;
		advance();
		prg_write = 1'b0;
	endtask

	// Access on a ce low cycle so a write here never hits a register
	task automatic cpu_probe(cpu_addr_t a, logic wr);
		advance();
		if (ce)
			advance();
		prg_ain = a;
		prg_write = wr;
		expect_value(K_PRG_AOUT,
			prg_addr_model(a, wr, mode_s, r6_s, r7_s, ram_en_s, ram_prot_s));
		expect_value(K_PRG_ALLOW, prg_allow_model(a, wr, ram_en_s, ram_prot_s));
		advance();
		prg_write = 1'b0;
	endtask

	task automatic ppu_probe(ppu_addr_t a, logic is_ram);
		advance();
		chr_ain = a;
		chr_is_ram = is_ram;
		expect_value(K_CHR_AOUT, chr_addr_model(a, inv_s, chr_s[0], chr_s[1], chr_s[2],
			chr_s[3], chr_s[4], chr_s[5]));
		expect_value(K_CHR_ALLOW, is_ram);
		expect_value(K_VRAM_A10, vram_a10_model(a, horiz_s));
		expect_value(K_VRAM_CE, a[13]); // Nametable space
	endtask

	// A12 high for 2 ce cycles, then low for at least low_ce ce cycles
	task automatic a12_pulse(int low_ce);
		logic counts;
		counts = a12_rise_counts(last_gap);
		advance();
		chr_ain = 14'h1000;
		repeat (3)
			advance();
		if (counts) begin
			count_m = irq_count_model(count_m, latch_m, reload_m);
			reload_m = 1'b0;
			if (count_m == 0 && enable_m)
				irq_m = 1'b1;
		end
		advance();
		chr_ain = '0;
		expect_value(K_IRQ, irq_m);
		repeat (2 * low_ce)
			advance();
		last_gap = low_ce;
	endtask

	task automatic run_irq(irq_count_t n, logic glitch);
		cpu_write(16'hC000, n);
		latch_m = n;
		cpu_write(16'hC001, 8'h00); // Reload on next count
		reload_m = 1'b1;
		cpu_write(16'hE001, 8'h00);
		enable_m = 1'b1;
		for (int p = 0; p <= n; p++) begin
			if (glitch) begin
				a12_pulse(4);
				a12_pulse(20); // Rises too soon, filtered out
			end else
				a12_pulse(20);
		end
		cpu_write(16'hE000, 8'h00); // Disable and acknowledge
		enable_m = 1'b0;
		irq_m = 1'b0;
		expect_value(K_IRQ, irq_m);
		advance();
	endtask

	task automatic finish_test(string name);
		advance(); // Last checks drain at the negedge
		$display("Test %-22s %0d checks, %0d errors", name,
			pass_cnt + fail_cnt - pass_mark - fail_mark, fail_cnt - fail_mark);
		pass_mark = pass_cnt;
		fail_mark = fail_cnt;
	endtask

	initial begin
		int k;
		mem_addr_t exp_v;
		mem_addr_t got;
		forever begin
			@(negedge clk);
			while (kind_q.size() > 0) begin
				k = kind_q.pop_front();
				exp_v = val_q.pop_front();
				got = output_of(k);
				assert (got === exp_v) pass_cnt++;
				else begin
					fail_cnt++;
					$display("** Error at time %0t: %s is %h, expected %h", $time,
						kind_name(k), got, exp_v);
				end
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		logic [15:0] r;
		rst = 1'b1;
		ce = 1'b0;
		prg_ain = '0;
		prg_write = 1'b0;
		prg_din = '0;
		chr_ain = '0;
		chr_is_ram = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int m = 0; m < 2; m++) begin
			mode_s = m[0];
			for (int s = 6; s < 8; s++) begin
				r = next_rand();
				cpu_write(16'h8000, {inv_s, mode_s, 3'b000, s[2:0]});
				cpu_write(16'h8001, r[7:0]);
				if (s == 6)
					r6_s = r[5:0];
				else
					r7_s = r[5:0];
			end
			for (int i = 0; i < 12; i++) begin
				r = next_rand();
				cpu_probe({1'b1, i[1:0], r[12:0]}, 1'b0); // Windows in turn
				cpu_probe({1'b1, i[1:0], r[12:0]}, 1'b1);
			end
		end
		finish_test("prg banking");

		for (int v = 0; v < 2; v++) begin
			inv_s = v[0];
			for (int s = 0; s < 6; s++) begin
				r = next_rand();
				cpu_write(16'h8000, {inv_s, mode_s, 3'b000, s[2:0]});
				cpu_write(16'h8001, r[7:0]);
				chr_s[s] = r[7:0];
			end
			for (int i = 0; i < 16; i++) begin
				r = next_rand();
				ppu_probe({1'b0, r[12:0]}, r[15]); // Pattern tables only
			end
		end
		finish_test("chr banking");

		for (int h = 0; h < 2; h++) begin
			horiz_s = h[0];
			cpu_write(16'hA000, {7'b0, horiz_s});
			for (int i = 0; i < 8; i++) begin
				r = next_rand();
				ppu_probe(r[13:0], r[15]);
			end
		end
		finish_test("mirroring");

		for (int c = 0; c < 4; c++) begin
			ram_en_s = c[1];
			ram_prot_s = c[0];
			cpu_write(16'hA001, {ram_en_s, ram_prot_s, 6'b0});
			for (int i = 0; i < 4; i++) begin
				r = next_rand();
				cpu_probe({3'b011, r[12:0]}, 1'b0);
				cpu_probe({3'b011, r[12:0]}, 1'b1);
			end
		end
		finish_test("prg ram");

		chr_ain = '0;
		repeat (40)
			advance(); // Let the A12 filter run out
		last_gap = 20;
		for (int n = 1; n <= 8; n++)
			run_irq(n[7:0], 1'b0);
		finish_test("scanline irq");

		run_irq(8'd3, 1'b1);
		finish_test("filter and disable");

		$display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
hdl/mmc3_pkg.sv
hdl/mmc3_reg_decode.sv
hdl/mmc3_prg_map.sv
hdl/mmc3_chr_map.sv
hdl/mmc3_scanline_irq.sv
hdl/mmc3_top.sv
tb/mmc3_tb.sv
